//--- src/fetchPkg.sv
// Shared widths and types of the instruction fetch block
package fetchPkg;

    // Address and PC width
    parameter int addrWidth = 32;

    // One instruction is one 32-bit word
    parameter int wordWidth = 32;

    // A cache line holds 16 instructions, refilled as one 512-bit block
    parameter int lineWords = 16;
    parameter int lineWidth = lineWords * wordWidth;

    // Byte offset inside a line, 64 bytes per line
    parameter int offsetBits = 6;

    // Word select inside a line, taken from pc[5:2]
    parameter int wordSelBits = 4;

    // One cache line seen two ways
    // The refill writes the whole block at once through raw
    // The fetch path picks one instruction through words, word 0 in the low bits
    typedef union packed {
        logic [lineWidth-1:0] raw;
        logic [lineWords-1:0][wordWidth-1:0] words;
    } cacheLine_u;

endpackage

//--- src/programCounter.sv
`timescale 1ns/100ps

// Program counter register and the sequential next address
module programCounter #(
    // Address fetched first after reset
    parameter logic [fetchPkg::addrWidth-1:0] ResetPC = '0
) (
    input  logic                           clk,
    input  logic                           rstN,
    // Pipeline halt
    input  logic                           halt,
    // Memory stage owns the memory for a DMA transfer
    input  logic                           stallDMAMem,
    // Decode cannot take another instruction yet
    input  logic                           blockInstruction,
    // A refill of the instruction cache is in flight
    input  logic                           cacheMiss,
    // Address chosen by the later stages
    input  logic [fetchPkg::addrWidth-1:0] nextPC,
    output logic [fetchPkg::addrWidth-1:0] pc,
    output logic [fetchPkg::addrWidth-1:0] pcPlus4
);

    import fetchPkg::*;

    logic                 hold;
    logic [addrWidth-1:0] pcNext;

    // Any one of the four sources freezes the fetch address
    assign hold = halt | stallDMAMem | blockInstruction | cacheMiss;

    // On the edge where a miss is first seen cacheMiss is still low
    // Decode keeps nextPC at pc while instrValid is low, so the fetch stays on the missing line
    assign pcNext = hold ? pc : nextPC;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= ResetPC;
        end else begin
            pc <= pcNext;
        end
    end

    // Sequential successor, a plain increment since instructions are word aligned
    assign pcPlus4 = pc + addrWidth'(4);

endmodule

//--- src/instrCache.sv
`timescale 1ns/100ps

// Direct-mapped instruction cache with 64-byte lines
// Lookup is combinational so instr and hit follow pc within the cycle
module instrCache #(
    // Number of lines, a power of two of at least 2
    parameter int NumLines  = 8,
    // Index field width, handed down from the top level
    parameter int IndexBits = $clog2(NumLines)
) (
    input  logic                           clk,
    input  logic                           rstN,
    // Fetch address, also the address of the line being filled
    input  logic [fetchPkg::addrWidth-1:0] pc,
    // Write strobe for a refilled line
    input  logic                           fillEn,
    // Whole line from the memory controller
    input  logic [fetchPkg::lineWidth-1:0] fillLine,
    output logic [fetchPkg::wordWidth-1:0] instr,
    output logic                           hit
);

    import fetchPkg::*;

    // Tag is everything above the index and the byte offset
    localparam int TagBits = addrWidth - offsetBits - IndexBits;

    // Address fields
    logic [TagBits-1:0]     tag;
    logic [IndexBits-1:0]   index;
    logic [wordSelBits-1:0] wordSel;

    // Storage arrays, one entry per line
    logic [TagBits-1:0]  tagArr [NumLines];
    logic [NumLines-1:0] validArr;
    cacheLine_u          lineArr [NumLines];

    // Line currently addressed by pc
    cacheLine_u readLine;

    // Split pc into tag, index and word select
    // The two lowest bits are the byte inside a word and are not used
    assign tag     = pc[addrWidth-1 -: TagBits];
    assign index   = pc[offsetBits +: IndexBits];
    assign wordSel = pc[offsetBits-1 -: wordSelBits];

    // Read side

    // Stored tag must match and the line must have been filled since reset
    assign hit = validArr[index] && (tagArr[index] == tag);

    // The line is read whole and the instruction picked through the word view
    assign readLine = lineArr[index];
    assign instr    = readLine.words[wordSel];

    // Write side

    // Valid bits are the only state that must start clean
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validArr <= '0;
        end else if (fillEn) begin
            validArr[index] <= 1'b1;
        end
    end

    // Tag and data follow the valid bit on the same edge
    // pc is held through the refill, so index and tag still name the missing line
    always_ff @(posedge clk) begin
        if (fillEn) begin
            tagArr[index]      <= tag;
            lineArr[index].raw <= fillLine;
        end
    end

endmodule

//--- src/refillController.sv
`timescale 1ns/100ps

// Refill sequencer for the instruction cache
// Idle watches for a miss, request waits for the line, wait lets the new line settle
module refillController (
    input  logic                           clk,
    input  logic                           rstN,
    // Fetch address, source of the miss address
    input  logic [fetchPkg::addrWidth-1:0] pc,
    // Lookup result from the cache
    input  logic                           hit,
    // One-cycle strobe from the memory controller, line data alongside it
    input  logic                           mcDataValid,
    // Level request to the memory controller, also freezes the PC
    output logic                           cacheMiss,
    // Line-aligned address of the missing line
    output logic [fetchPkg::addrWidth-1:0] missAddr,
    // Line write into the cache
    output logic                           fillEn,
    // Instruction on instr is good for decode
    output logic                           instrValid
);

    import fetchPkg::*;

    typedef enum logic [1:0] {
        stateIdle    = 2'b00,
        stateRequest = 2'b01,
        stateWait    = 2'b10
    } refillState_e;

    refillState_e state;
    refillState_e stateNext;

    always_comb begin
        stateNext = stateIdle;
        case (state)
            // A miss seen here starts a refill at the next edge
            stateIdle: stateNext = hit ? stateIdle : stateRequest;
            // The controller may take any number of cycles to answer
            stateRequest: stateNext = mcDataValid ? stateWait : stateRequest;
            // One cycle for the written line to show as a hit
            stateWait: stateNext = stateIdle;
            default: stateNext = stateIdle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= stateIdle;
        end else begin
            state <= stateNext;
        end
    end

    // Captured only when leaving idle, so it holds for the whole refill
    always_ff @(posedge clk) begin
        if (state == stateIdle && !hit) begin
            missAddr <= {pc[addrWidth-1:offsetBits], {offsetBits{1'b0}}};
        end
    end

    // High in request and in wait, so the PC stays put until the hit is back
    assign cacheMiss = (state != stateIdle);

    // A strobe outside request is stray and must not touch the cache
    assign fillEn = mcDataValid && (state == stateRequest);

    // Only idle presents a lookup that decode may use
    assign instrValid = hit && (state == stateIdle);

endmodule

//--- src/fetchStage.sv
`timescale 1ns/100ps

// Instruction fetch stage
// Program counter, instruction cache and its refill sequencer
module fetchStage #(
    // Number of cache lines, a power of two of at least 2
    parameter int                            NumLines = 8,
    // Address fetched first after reset
    parameter logic [fetchPkg::addrWidth-1:0] ResetPC = '0
) (
    input  logic                           clk,
    input  logic                           rstN,
    // Pipeline control
    input  logic                           halt,
    input  logic                           stallDMAMem,
    input  logic                           blockInstruction,
    // Redirect or sequential address from the later stages
    input  logic [fetchPkg::addrWidth-1:0] nextPC,
    // Memory controller return path
    input  logic                           mcDataValid,
    input  logic [fetchPkg::lineWidth-1:0] mcDataIn,
    // Towards decode
    output logic [fetchPkg::addrWidth-1:0] pc,
    output logic [fetchPkg::wordWidth-1:0] instr,
    output logic                           instrValid,
    output logic [fetchPkg::addrWidth-1:0] pcPlus4,
    // Towards the memory controller
    output logic                           cacheMiss,
    output logic [fetchPkg::addrWidth-1:0] missAddr
);

    // Width of the cache index field
    localparam int IndexBits = $clog2(NumLines);

    logic hit;
    logic fillEn;

    programCounter #(
        .ResetPC(ResetPC)
    ) pcReg (
        .clk(clk),
        .rstN(rstN),
        .halt(halt),
        .stallDMAMem(stallDMAMem),
        .blockInstruction(blockInstruction),
        .cacheMiss(cacheMiss),
        .nextPC(nextPC),
        .pc(pc),
        .pcPlus4(pcPlus4)
    );

    // The refill line goes straight from the memory controller into the cache
    instrCache #(
        .NumLines(NumLines),
        .IndexBits(IndexBits)
    ) icache (
        .clk(clk),
        .rstN(rstN),
        .pc(pc),
        .fillEn(fillEn),
        .fillLine(mcDataIn),
        .instr(instr),
        .hit(hit)
    );

    refillController refill (
        .clk(clk),
        .rstN(rstN),
        .pc(pc),
        .hit(hit),
        .mcDataValid(mcDataValid),
        .cacheMiss(cacheMiss),
        .missAddr(missAddr),
        .fillEn(fillEn),
        .instrValid(instrValid)
    );

endmodule

//--- verification/fetchStage_properties.sv
`timescale 1ns/100ps

// Protocol and stall checks on the fetch stage, attached to every fetchStage by bind
module fetchStage_properties (
    input logic                           clk,
    input logic                           rstN,
    input logic                           halt,
    input logic                           stallDMAMem,
    input logic                           blockInstruction,
    input logic [fetchPkg::addrWidth-1:0] nextPC,
    input logic [fetchPkg::addrWidth-1:0] pc,
    input logic                           instrValid,
    input logic                           cacheMiss,
    input logic [fetchPkg::addrWidth-1:0] missAddr,
    // Internal line write strobe of the stage
    input logic                           fillEn
);

    import fetchPkg::*;

    // Number of failed assertions, polled by the testbench
    int failCount = 0;

    logic holdAny;

    // Same four hold sources the PC register combines
    assign holdAny = halt | stallDMAMem | blockInstruction | cacheMiss;

    // A held edge leaves the PC alone
    pcHeld: assert property (@(posedge clk) disable iff (!rstN)
        holdAny |=> $stable(pc))
    else begin
        failCount++;
        $error("pc changed across an edge with a hold active");
    end

    // An edge without hold loads the address offered by the later stages
    pcLoadsNext: assert property (@(posedge clk) disable iff (!rstN)
        !holdAny |=> pc == $past(nextPC))
    else begin
        failCount++;
        $error("pc did not take nextPC across an edge without hold");
    end

    // The request address must not move while the controller works on it
    missAddrStable: assert property (@(posedge clk) disable iff (!rstN)
        cacheMiss |=> !cacheMiss || $stable(missAddr))
    else begin
        failCount++;
        $error("missAddr changed while cacheMiss was high");
    end

    missAddrAligned: assert property (@(posedge clk) disable iff (!rstN)
        cacheMiss |-> missAddr[offsetBits-1:0] == '0)
    else begin
        failCount++;
        $error("missAddr is not 64-byte aligned");
    end

    // One edge after the fill the stage sits in its wait state
    refillWaits: assert property (@(posedge clk) disable iff (!rstN)
        fillEn |=> cacheMiss)
    else begin
        failCount++;
        $error("cacheMiss dropped one edge after the line fill");
    end

    // Two edges after the fill the request is gone and the new line hits
    refillEnds: assert property (@(posedge clk) disable iff (!rstN)
        $past(fillEn, 2) |-> !cacheMiss && instrValid)
    else begin
        failCount++;
        $error("refill did not end with a hit two edges after the line fill");
    end

    // Decode only sees valid instructions from the idle state
    validOnlyIdle: assert property (@(posedge clk) disable iff (!rstN)
        instrValid |-> !cacheMiss)
    else begin
        failCount++;
        $error("instrValid high during a refill");
    end

endmodule

bind fetchStage fetchStage_properties props (
    .clk(clk),
    .rstN(rstN),
    .halt(halt),
    .stallDMAMem(stallDMAMem),
    .blockInstruction(blockInstruction),
    .nextPC(nextPC),
    .pc(pc),
    .instrValid(instrValid),
    .cacheMiss(cacheMiss),
    .missAddr(missAddr),
    .fillEn(fillEn)
);

//--- verification/fetchTb.sv
`timescale 1ns/100ps

// Testbench for the instruction fetch stage
// Plays decode and the later stages around fetch, and the memory controller behind the cache
module fetchTb;

    import fetchPkg::*;

    // Cache geometry as seen by the checker
    localparam int CacheLines = 8;
    localparam int IndexBits  = $clog2(CacheLines);
    localparam int TagBits    = addrWidth - offsetBits - IndexBits;

    // First fetch address after reset, inside the 4 KB jump window
    localparam logic [addrWidth-1:0] ResetAddr = 32'h0000_0100;

    // Stimulus length and the hard cycle limit of the whole run
    localparam int StimCycles = 2000;
    localparam int CycleLimit = 3000;

    // Memory controller model states
    typedef enum logic [1:0] {
        mcStateIdle,
        mcStateDelay,
        mcStateDone
    } modelState_e;

    logic                 clk = 1'b0;
    logic                 rstN;
    logic                 halt;
    logic                 stallDMAMem;
    logic                 blockInstruction;
    logic [addrWidth-1:0] nextPC;
    logic                 mcDataValid;
    logic [lineWidth-1:0] mcDataIn;
    logic [addrWidth-1:0] pc;
    logic [wordWidth-1:0] instr;
    logic                 instrValid;
    logic [addrWidth-1:0] pcPlus4;
    logic                 cacheMiss;
    logic [addrWidth-1:0] missAddr;

    // Backing memory, one random line per line-aligned address once it was requested
    cacheLine_u memLines [logic [addrWidth-1:0]];

    // Mirror of the valid bits and tags, updated with every delivered line
    logic               mirrorValid [CacheLines];
    logic [TagBits-1:0] mirrorTag [CacheLines];

    modelState_e          mcState;
    int                   waitLeft;
    // Lookup of the previous cycle, used to predict cacheMiss after the edge
    logic                 prevIdle;
    logic                 prevMissExpected;
    logic [addrWidth-1:0] lookupPc;
    int                   cycleCount = 0;

    fetchStage #(
        .NumLines(CacheLines),
        .ResetPC(ResetAddr)
    ) dut (
        .clk(clk),
        .rstN(rstN),
        .halt(halt),
        .stallDMAMem(stallDMAMem),
        .blockInstruction(blockInstruction),
        .nextPC(nextPC),
        .mcDataValid(mcDataValid),
        .mcDataIn(mcDataIn),
        .pc(pc),
        .instr(instr),
        .instrValid(instrValid),
        .pcPlus4(pcPlus4),
        .cacheMiss(cacheMiss),
        .missAddr(missAddr)
    );

    // 100 ns period
    always #50 clk = ~clk;

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped");
    endtask

    function automatic logic [IndexBits-1:0] lineIndex(input logic [addrWidth-1:0] addr);
        return addr[offsetBits +: IndexBits];
    endfunction

    function automatic logic [TagBits-1:0] lineTag(input logic [addrWidth-1:0] addr);
        return addr[addrWidth-1 -: TagBits];
    endfunction

    // Sixteen random instruction words packed as one line
    function automatic cacheLine_u randomLine();
        cacheLine_u line;
        for (int w = 0; w < lineWords; w++) begin
            line.words[w] = $urandom;
        end
        return line;
    endfunction

    task automatic checkResetState();
        assert (pc == ResetAddr)
            else stopRun($sformatf("Error at %0d ns: pc is %h after reset, expected %h",
                $time, pc, ResetAddr));
        assert (!cacheMiss)
            else stopRun($sformatf("Error at %0d ns: cacheMiss is high after reset", $time));
        assert (!instrValid)
            else stopRun($sformatf("Error at %0d ns: instrValid is high after reset", $time));
    endtask

    task automatic checkOutputs();
        logic [addrWidth-1:0] key;
        cacheLine_u           expLine;
        logic                 expectMiss;
        expectMiss = 1'b0;
        assert (pcPlus4 == pc + 32'd4)
            else stopRun($sformatf("Error at %0d ns: pcPlus4 is %h, expected %h",
                $time, pcPlus4, pc + 32'd4));
        // An idle lookup decides whether a refill starts at the next edge
        if (prevIdle) begin
            assert (cacheMiss == prevMissExpected)
                else stopRun($sformatf(
                    "Error at %0d ns: cacheMiss is %b after lookup of %h, expected %b",
                    $time, cacheMiss, lookupPc, prevMissExpected));
        end
        if (!cacheMiss) begin
            expectMiss = !(mirrorValid[lineIndex(pc)] && mirrorTag[lineIndex(pc)] == lineTag(pc));
            assert (instrValid == !expectMiss)
                else stopRun($sformatf(
                    "Error at %0d ns: instrValid is %b for pc %h, expected %b",
                    $time, instrValid, pc, !expectMiss));
        end
        prevIdle         = !cacheMiss;
        prevMissExpected = expectMiss;
        lookupPc         = pc;
        if (instrValid) begin
            key = {pc[addrWidth-1:offsetBits], {offsetBits{1'b0}}};
            assert (memLines.exists(key))
                else stopRun($sformatf("Error at %0d ns: hit at pc %h on a line never delivered",
                    $time, pc));
            expLine = memLines[key];
            assert (instr == expLine.words[pc[offsetBits-1:2]])
                else stopRun($sformatf("Error at %0d ns: instr is %h at pc %h, expected %h",
                    $time, instr, pc, expLine.words[pc[offsetBits-1:2]]));
        end
    endtask

    // Puts the requested line on the bus for one cycle and records it in the mirror
    task automatic deliverLine();
        logic [addrWidth-1:0] key;
        key = missAddr;
        assert (key == {pc[addrWidth-1:offsetBits], {offsetBits{1'b0}}})
            else stopRun($sformatf(
                "Error at %0d ns: missAddr %h does not hold the line of pc %h",
                $time, missAddr, pc));
        if (!memLines.exists(key)) begin
            memLines[key] = randomLine();
        end
        mcDataValid                = 1'b1;
        mcDataIn                   = memLines[key].raw;
        mirrorValid[lineIndex(key)] = 1'b1;
        mirrorTag[lineIndex(key)]   = lineTag(key);
    endtask

    task automatic driveMemory();
        cacheLine_u strayLine;
        mcDataValid = 1'b0;
        // The refill is over once the fetch side has left its wait state
        if (mcState == mcStateDone && !cacheMiss) begin
            mcState = mcStateIdle;
        end
        if (mcState == mcStateIdle && cacheMiss) begin
            waitLeft = $urandom_range(6, 0);
            mcState  = mcStateDelay;
        end
        if (mcState == mcStateDelay) begin
            if (waitLeft == 0) begin
                deliverLine();
                mcState = mcStateDone;
            end else begin
                waitLeft = waitLeft - 1;
            end
        end else if (mcState == mcStateIdle && $urandom_range(15, 0) == 0) begin
            // A stray strobe while no refill runs carries garbage that the cache must ignore
            strayLine   = randomLine();
            mcDataValid = 1'b1;
            mcDataIn    = strayLine.raw;
        end
    endtask

    task automatic drivePipeline();
        logic [addrWidth-1:0] jumpTarget;
        // Word aligned inside 4 KB, eight times the cache size, so tags collide often
        jumpTarget       = $urandom & 32'h0000_0FFC;
        halt             = ($urandom_range(11, 0) == 0);
        stallDMAMem      = ($urandom_range(13, 0) == 0);
        blockInstruction = ($urandom_range(9, 0) == 0);
        // Decode keeps the fetch on the current address until an instruction is valid
        if (!instrValid) begin
            nextPC = pc;
        end else if ($urandom_range(7, 0) == 0) begin
            nextPC = jumpTarget;
        end else begin
            nextPC = pcPlus4;
        end
    endtask

    // Timeout and the link to the bound protocol checks
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CycleLimit) begin
            stopRun("Timeout: the run exceeded its cycle limit");
        end else if (dut.props.failCount != 0) begin
            stopRun("A protocol assertion on fetchStage failed");
        end
    end

    initial begin
        int cyc;
        int i;
        void'($urandom(71069));
        rstN             = 1'b0;
        halt             = 1'b0;
        stallDMAMem      = 1'b0;
        blockInstruction = 1'b0;
        nextPC           = ResetAddr;
        mcDataValid      = 1'b0;
        mcDataIn         = '0;
        mcState          = mcStateIdle;
        waitLeft         = 0;
        prevIdle         = 1'b0;
        prevMissExpected = 1'b0;
        lookupPc         = '0;
        for (i = 0; i < CacheLines; i++) begin
            mirrorValid[i] = 1'b0;
            mirrorTag[i]   = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        checkResetState();
        rstN = 1'b1;
        for (cyc = 0; cyc < StimCycles; cyc++) begin
            @(negedge clk);
            checkOutputs();
            driveMemory();
            drivePipeline();
        end
        if (dut.props.failCount != 0) begin
            stopRun("A protocol assertion on fetchStage failed during the run");
        end else begin
            $display("Finished with no errors");
            $finish;
        end
    end

endmodule

//--- compile.f
src/fetchPkg.sv
src/programCounter.sv
src/instrCache.sv
src/refillController.sv
src/fetchStage.sv
verification/fetchStage_properties.sv
verification/fetchTb.sv

//--- Makefile
TOP := fetchTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only -Wall --top-module fetchStage \
		src/fetchPkg.sv src/programCounter.sv src/instrCache.sv \
		src/refillController.sv src/fetchStage.sv

clean:
	rm -rf obj_dir sim.log
